// File: include/glb_defs.svh
// Size parameters for one global buffer tile.
// Included by the package and by every module that sizes a port from them.

`ifndef GLB_DEFS_SVH
`define GLB_DEFS_SVH

// banks held inside one tile
`define GLB_BANKS_PER_TILE 4

// word address inside a single bank
`define GLB_BANK_ADDR_WIDTH 8

// bank index field of a global address
`define GLB_BANK_SEL_WIDTH 2

// tile index field of a global address
`define GLB_TILE_SEL_WIDTH 3

// full global address, tile field on top
`define GLB_ADDR_WIDTH (`GLB_TILE_SEL_WIDTH + `GLB_BANK_SEL_WIDTH + `GLB_BANK_ADDR_WIDTH)

`define GLB_DATA_WIDTH 32

`endif

// File: source/glb_pkg.sv
// Shared types for the global buffer tile.
// Modules pull these in with a wildcard import in their header.

`default_nettype none

package glb_pkg;

`include "glb_defs.svh"

    // tile | bank | word, from the top bit down
    typedef logic [`GLB_ADDR_WIDTH-1:0]      glb_addr_t;
    typedef logic [`GLB_DATA_WIDTH-1:0]      glb_data_t;
    typedef logic [`GLB_TILE_SEL_WIDTH-1:0]  glb_tile_id_t;
    typedef logic [`GLB_BANK_SEL_WIDTH-1:0]  glb_bank_sel_t;
    typedef logic [`GLB_BANK_ADDR_WIDTH-1:0] glb_bank_addr_t;

    // zero means the DMA path is off
    typedef logic [1:0] glb_dma_mode_t;

    // which requester owns a read in flight
    typedef enum logic [1:0] {
        NONE     = 2'd0,
        PROC     = 2'd1,
        STRM_DMA = 2'd2,
        STRM_RTR = 2'd3
    } glb_rd_src_t;

endpackage

`default_nettype wire

// File: source/glb_bank.sv
// One SRAM bank of the tile, single write port and registered read port.
// Both ports act only on active clock edges.

`timescale 1ns/1ps
`default_nettype none

`include "glb_defs.svh"

module glb_bank import glb_pkg::*; (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           clk_en,
    input  wire logic           wr_en,
    input  wire glb_bank_addr_t wr_addr,
    input  wire glb_data_t      wr_data,
    input  wire logic           rd_en,
    input  wire glb_bank_addr_t rd_addr,
    output logic                rd_valid,
    output glb_data_t           rd_data
);

    localparam int DEPTH = 1 << `GLB_BANK_ADDR_WIDTH;

    glb_data_t mem [DEPTH];

    // write and read in the same cycle to one word returns the old word
    always_ff @(posedge clk) begin
        if (clk_en) begin
            if (wr_en) begin
                mem[wr_addr] <= wr_data;
            end
            if (rd_en) begin
                rd_data <= mem[rd_addr];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else if (clk_en) begin
            rd_valid <= rd_en;
        end
    end

endmodule

`default_nettype wire

// File: source/glb_core_switch.sv
// Core channel switch of a global buffer tile.
// Picks one write and one read per cycle, filters on tile id, drives the banks
// and steers bank responses back to the requester after a fixed latency.

`timescale 1ns/1ps
`default_nettype none

`include "glb_defs.svh"

module glb_core_switch import glb_pkg::*; (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           clk_en,
    input  wire glb_tile_id_t   glb_tile_id,
    input  wire glb_dma_mode_t  cfg_st_dma_mode,
    input  wire glb_dma_mode_t  cfg_ld_dma_mode,

    // processor port
    input  wire logic           proc_wr_en,
    input  wire glb_addr_t      proc_wr_addr,
    input  wire glb_data_t      proc_wr_data,
    input  wire logic           proc_rd_en,
    input  wire glb_addr_t      proc_rd_addr,

    // stream dma engine
    input  wire logic           strm_dma_wr_en,
    input  wire glb_addr_t      strm_dma_wr_addr,
    input  wire glb_data_t      strm_dma_wr_data,
    input  wire logic           strm_dma_rd_en,
    input  wire glb_addr_t      strm_dma_rd_addr,

    // stream router chain, from the previous tile
    input  wire logic           strm_rtr_wr_en,
    input  wire glb_addr_t      strm_rtr_wr_addr,
    input  wire glb_data_t      strm_rtr_wr_data,
    input  wire logic           strm_rtr_rd_en,
    input  wire glb_addr_t      strm_rtr_rd_addr,

    // pass-through toward the next tile
    output logic                chain_wr_en,
    output glb_addr_t           chain_wr_addr,
    output glb_data_t           chain_wr_data,
    output logic                chain_rd_en,
    output glb_addr_t           chain_rd_addr,

    input  wire logic           chain_rsp_valid,
    input  wire glb_data_t      chain_rsp_data,

    // responses
    output logic                proc_rsp_valid,
    output glb_data_t           proc_rsp_data,
    output logic                strm_rtr_rsp_valid,
    output glb_data_t           strm_rtr_rsp_data,
    output logic                strm_dma_rsp_valid,
    output glb_data_t           strm_dma_rsp_data,

    // bank side
    output logic [`GLB_BANKS_PER_TILE-1:0] bank_wr_en,
    output glb_bank_addr_t      bank_wr_addr,
    output glb_data_t           bank_wr_data,
    output logic [`GLB_BANKS_PER_TILE-1:0] bank_rd_en,
    output glb_bank_addr_t      bank_rd_addr,
    input  wire logic [`GLB_BANKS_PER_TILE-1:0] bank_rd_valid,
    input  wire glb_data_t      bank_rd_data [`GLB_BANKS_PER_TILE]
);

    localparam int WORD_W = `GLB_BANK_ADDR_WIDTH;
    localparam int BANK_W = `GLB_BANK_SEL_WIDTH;

    logic           st_dma_on;
    logic           ld_dma_on;

    logic           wr_en_mux;
    glb_addr_t      wr_addr_mux;
    glb_data_t      wr_data_mux;
    logic [`GLB_BANKS_PER_TILE-1:0] wr_onehot;

    glb_rd_src_t    rd_src;
    glb_addr_t      rd_addr_mux;
    logic [`GLB_BANKS_PER_TILE-1:0] rd_onehot;

    // read owner and bank travel alongside the bank access
    glb_rd_src_t    rd_src_q0;
    glb_rd_src_t    rd_src_q1;
    glb_rd_src_t    rd_src_q2;
    glb_bank_sel_t  rd_bank_q0;
    glb_bank_sel_t  rd_bank_q1;
    glb_bank_sel_t  rd_bank_q2;

    logic [`GLB_BANKS_PER_TILE-1:0] rsp_valid_q;
    glb_data_t      rsp_data_q [`GLB_BANKS_PER_TILE];

    logic           local_valid;
    glb_data_t      local_data;

    function automatic logic tile_hit(glb_addr_t addr, glb_tile_id_t id);
        return addr[WORD_W + BANK_W +: `GLB_TILE_SEL_WIDTH] == id;
    endfunction

    function automatic glb_bank_sel_t bank_of(glb_addr_t addr);
        return addr[WORD_W +: BANK_W];
    endfunction

    assign st_dma_on = (cfg_st_dma_mode != 2'b00);
    assign ld_dma_on = (cfg_ld_dma_mode != 2'b00);

    // write source: processor first, then whichever stream path is active
    always_comb begin
        if (proc_wr_en) begin
            wr_en_mux   = proc_wr_en;
            wr_addr_mux = proc_wr_addr;
            wr_data_mux = proc_wr_data;
        end else if (st_dma_on) begin
            wr_en_mux   = strm_dma_wr_en;
            wr_addr_mux = strm_dma_wr_addr;
            wr_data_mux = strm_dma_wr_data;
        end else begin
            wr_en_mux   = strm_rtr_wr_en;
            wr_addr_mux = strm_rtr_wr_addr;
            wr_data_mux = strm_rtr_wr_data;
        end
    end

    always_comb begin
        wr_onehot = '0;
        if (wr_en_mux && tile_hit(wr_addr_mux, glb_tile_id)) begin
            wr_onehot[bank_of(wr_addr_mux)] = 1'b1;
        end
    end

    // read source, only requests aimed at this tile count
    always_comb begin
        if (proc_rd_en && tile_hit(proc_rd_addr, glb_tile_id)) begin
            rd_src = PROC;
        end else if (ld_dma_on && strm_dma_rd_en && tile_hit(strm_dma_rd_addr, glb_tile_id)) begin
            rd_src = STRM_DMA;
        end else if (!ld_dma_on && strm_rtr_rd_en
                     && tile_hit(strm_rtr_rd_addr, glb_tile_id)) begin
            rd_src = STRM_RTR;
        end else begin
            rd_src = NONE;
        end
    end

    always_comb begin
        case (rd_src)
            PROC:     rd_addr_mux = proc_rd_addr;
            STRM_DMA: rd_addr_mux = strm_dma_rd_addr;
            STRM_RTR: rd_addr_mux = strm_rtr_rd_addr;
            default:  rd_addr_mux = '0;
        endcase
    end

    always_comb begin
        rd_onehot = '0;
        if (rd_src != NONE) begin
            rd_onehot[bank_of(rd_addr_mux)] = 1'b1;
        end
    end

    // request register toward the banks
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bank_wr_en <= '0;
            bank_rd_en <= '0;
            rd_src_q0  <= NONE;
            rd_src_q1  <= NONE;
            rd_src_q2  <= NONE;
        end else if (clk_en) begin
            bank_wr_en <= wr_onehot;
            bank_rd_en <= rd_onehot;
            rd_src_q0  <= rd_src;
            rd_src_q1  <= rd_src_q0;
            rd_src_q2  <= rd_src_q1;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_en) begin
            bank_wr_addr <= wr_addr_mux[WORD_W-1:0];
            bank_wr_data <= wr_data_mux;
            bank_rd_addr <= rd_addr_mux[WORD_W-1:0];
            rd_bank_q0   <= bank_of(rd_addr_mux);
            rd_bank_q1   <= rd_bank_q0;
            rd_bank_q2   <= rd_bank_q1;
        end
    end

    // bank response stage, lines up with rd_src_q2
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp_valid_q <= '0;
        end else if (clk_en) begin
            rsp_valid_q <= bank_rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_en) begin
            for (int i = 0; i < `GLB_BANKS_PER_TILE; i++) begin
                rsp_data_q[i] <= bank_rd_data[i];
            end
        end
    end

    assign local_valid = rsp_valid_q[rd_bank_q2];
    assign local_data  = rsp_data_q[rd_bank_q2];

    // processor only ever sees its own reads
    assign proc_rsp_valid = (rd_src_q2 == PROC) ? local_valid : 1'b0;
    assign proc_rsp_data  = (rd_src_q2 == PROC) ? local_data : '0;

    // local stream reads win, chain responses fill the gaps
    always_comb begin
        if (rd_src_q2 == STRM_DMA || rd_src_q2 == STRM_RTR) begin
            strm_rtr_rsp_valid = local_valid;
            strm_rtr_rsp_data  = local_data;
        end else begin
            strm_rtr_rsp_valid = chain_rsp_valid;
            strm_rtr_rsp_data  = chain_rsp_data;
        end
    end

    assign strm_dma_rsp_valid = ld_dma_on ? chain_rsp_valid : 1'b0;
    assign strm_dma_rsp_data  = ld_dma_on ? chain_rsp_data : '0;

    // stream packets continue down the chain unfiltered
    assign chain_wr_en   = st_dma_on ? strm_dma_wr_en : strm_rtr_wr_en;
    assign chain_wr_addr = st_dma_on ? strm_dma_wr_addr : strm_rtr_wr_addr;
    assign chain_wr_data = st_dma_on ? strm_dma_wr_data : strm_rtr_wr_data;
    assign chain_rd_en   = ld_dma_on ? strm_dma_rd_en : strm_rtr_rd_en;
    assign chain_rd_addr = ld_dma_on ? strm_dma_rd_addr : strm_rtr_rd_addr;

endmodule

`default_nettype wire

// File: source/glb_tile.sv
// Top level of one global buffer tile.
// Connects the core channel switch to its four SRAM banks.

`timescale 1ns/1ps
`default_nettype none

`include "glb_defs.svh"

module glb_tile import glb_pkg::*; (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           clk_en,
    input  wire glb_tile_id_t   glb_tile_id,
    input  wire glb_dma_mode_t  cfg_st_dma_mode,
    input  wire glb_dma_mode_t  cfg_ld_dma_mode,

    input  wire logic           proc_wr_en,
    input  wire glb_addr_t      proc_wr_addr,
    input  wire glb_data_t      proc_wr_data,
    input  wire logic           proc_rd_en,
    input  wire glb_addr_t      proc_rd_addr,

    input  wire logic           strm_dma_wr_en,
    input  wire glb_addr_t      strm_dma_wr_addr,
    input  wire glb_data_t      strm_dma_wr_data,
    input  wire logic           strm_dma_rd_en,
    input  wire glb_addr_t      strm_dma_rd_addr,

    input  wire logic           strm_rtr_wr_en,
    input  wire glb_addr_t      strm_rtr_wr_addr,
    input  wire glb_data_t      strm_rtr_wr_data,
    input  wire logic           strm_rtr_rd_en,
    input  wire glb_addr_t      strm_rtr_rd_addr,

    output logic                chain_wr_en,
    output glb_addr_t           chain_wr_addr,
    output glb_data_t           chain_wr_data,
    output logic                chain_rd_en,
    output glb_addr_t           chain_rd_addr,

    input  wire logic           chain_rsp_valid,
    input  wire glb_data_t      chain_rsp_data,

    output logic                proc_rsp_valid,
    output glb_data_t           proc_rsp_data,
    output logic                strm_rtr_rsp_valid,
    output glb_data_t           strm_rtr_rsp_data,
    output logic                strm_dma_rsp_valid,
    output glb_data_t           strm_dma_rsp_data
);

    // switch to bank
    logic [`GLB_BANKS_PER_TILE-1:0] bank_wr_en;
    glb_bank_addr_t                 bank_wr_addr;
    glb_data_t                      bank_wr_data;
    logic [`GLB_BANKS_PER_TILE-1:0] bank_rd_en;
    glb_bank_addr_t                 bank_rd_addr;

    // bank to switch
    logic [`GLB_BANKS_PER_TILE-1:0] bank_rd_valid;
    glb_data_t                      bank_rd_data [`GLB_BANKS_PER_TILE];

    glb_core_switch u_switch (
        .clk                (clk),
        .reset              (reset),
        .clk_en             (clk_en),
        .glb_tile_id        (glb_tile_id),
        .cfg_st_dma_mode    (cfg_st_dma_mode),
        .cfg_ld_dma_mode    (cfg_ld_dma_mode),
        .proc_wr_en         (proc_wr_en),
        .proc_wr_addr       (proc_wr_addr),
        .proc_wr_data       (proc_wr_data),
        .proc_rd_en         (proc_rd_en),
        .proc_rd_addr       (proc_rd_addr),
        .strm_dma_wr_en     (strm_dma_wr_en),
        .strm_dma_wr_addr   (strm_dma_wr_addr),
        .strm_dma_wr_data   (strm_dma_wr_data),
        .strm_dma_rd_en     (strm_dma_rd_en),
        .strm_dma_rd_addr   (strm_dma_rd_addr),
        .strm_rtr_wr_en     (strm_rtr_wr_en),
        .strm_rtr_wr_addr   (strm_rtr_wr_addr),
        .strm_rtr_wr_data   (strm_rtr_wr_data),
        .strm_rtr_rd_en     (strm_rtr_rd_en),
        .strm_rtr_rd_addr   (strm_rtr_rd_addr),
        .chain_wr_en        (chain_wr_en),
        .chain_wr_addr      (chain_wr_addr),
        .chain_wr_data      (chain_wr_data),
        .chain_rd_en        (chain_rd_en),
        .chain_rd_addr      (chain_rd_addr),
        .chain_rsp_valid    (chain_rsp_valid),
        .chain_rsp_data     (chain_rsp_data),
        .proc_rsp_valid     (proc_rsp_valid),
        .proc_rsp_data      (proc_rsp_data),
        .strm_rtr_rsp_valid (strm_rtr_rsp_valid),
        .strm_rtr_rsp_data  (strm_rtr_rsp_data),
        .strm_dma_rsp_valid (strm_dma_rsp_valid),
        .strm_dma_rsp_data  (strm_dma_rsp_data),
        .bank_wr_en         (bank_wr_en),
        .bank_wr_addr       (bank_wr_addr),
        .bank_wr_data       (bank_wr_data),
        .bank_rd_en         (bank_rd_en),
        .bank_rd_addr       (bank_rd_addr),
        .bank_rd_valid      (bank_rd_valid),
        .bank_rd_data       (bank_rd_data)
    );

    // address and data are shared, enables pick the bank
    for (genvar i = 0; i < `GLB_BANKS_PER_TILE; i++) begin : u_bank
        glb_bank u_mem (
            .clk      (clk),
            .reset    (reset),
            .clk_en   (clk_en),
            .wr_en    (bank_wr_en[i]),
            .wr_addr  (bank_wr_addr),
            .wr_data  (bank_wr_data),
            .rd_en    (bank_rd_en[i]),
            .rd_addr  (bank_rd_addr),
            .rd_valid (bank_rd_valid[i]),
            .rd_data  (bank_rd_data[i])
        );
    end

endmodule

`default_nettype wire

// File: sim/glb_tb_clock.sv
// Clock and reset source for the tile testbench.
// Reset is held high for the first few rising edges, then released.

`timescale 1ns/1ps
`default_nettype none

module glb_tb_clock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // released 1 ns after the edge, like the rest of the stimulus
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: sim/glb_tile_tb.sv
// Directed testbench for one global buffer tile.
// A reference memory and per-port response queues predict every output on every cycle.

`timescale 1ns/1ps
`default_nettype none

`include "glb_defs.svh"

module glb_tile_tb import glb_pkg::*; ();

    localparam glb_tile_id_t TILE_ID = 3'd5;
    localparam int LATENCY     = 3;
    localparam int CLK_PERIOD  = 8;
    localparam int WORDS       = 1 << `GLB_BANK_ADDR_WIDTH;
    // five short directed tests plus the random sweep
    localparam int TEST_CYCLES = 5 * 40 + 220;
    localparam int TIMEOUT_NS  = (TEST_CYCLES + 100) * CLK_PERIOD;

    typedef struct packed {
        int        due;
        glb_data_t data;
    } rsp_t;

    logic          clk;
    logic          reset;
    logic          clk_en;
    glb_tile_id_t  glb_tile_id;
    glb_dma_mode_t cfg_st_dma_mode;
    glb_dma_mode_t cfg_ld_dma_mode;
    logic          proc_wr_en;
    glb_addr_t     proc_wr_addr;
    glb_data_t     proc_wr_data;
    logic          proc_rd_en;
    glb_addr_t     proc_rd_addr;
    logic          strm_dma_wr_en;
    glb_addr_t     strm_dma_wr_addr;
    glb_data_t     strm_dma_wr_data;
    logic          strm_dma_rd_en;
    glb_addr_t     strm_dma_rd_addr;
    logic          strm_rtr_wr_en;
    glb_addr_t     strm_rtr_wr_addr;
    glb_data_t     strm_rtr_wr_data;
    logic          strm_rtr_rd_en;
    glb_addr_t     strm_rtr_rd_addr;
    logic          chain_wr_en;
    glb_addr_t     chain_wr_addr;
    glb_data_t     chain_wr_data;
    logic          chain_rd_en;
    glb_addr_t     chain_rd_addr;
    logic          chain_rsp_valid;
    glb_data_t     chain_rsp_data;
    logic          proc_rsp_valid;
    glb_data_t     proc_rsp_data;
    logic          strm_rtr_rsp_valid;
    glb_data_t     strm_rtr_rsp_data;
    logic          strm_dma_rsp_valid;
    glb_data_t     strm_dma_rsp_data;

    // reference state
    glb_data_t   ref_mem [`GLB_BANKS_PER_TILE][WORDS];
    logic        written [`GLB_BANKS_PER_TILE][WORDS];
    rsp_t        proc_q [$];
    rsp_t        strm_q [$];
    int          act_cycles = 0;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] rng_state = 32'd80;

    glb_tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(2)) u_clock (
        .clk   (clk),
        .reset (reset)
    );

    glb_tile dut (.*);

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic glb_addr_t make_addr(glb_tile_id_t tile, glb_bank_sel_t bank,
                                            glb_bank_addr_t word);
        return {tile, bank, word};
    endfunction

    function automatic glb_tile_id_t tile_field(glb_addr_t a);
        return a[`GLB_ADDR_WIDTH-1 -: `GLB_TILE_SEL_WIDTH];
    endfunction

    function automatic glb_bank_sel_t bank_field(glb_addr_t a);
        return a[`GLB_BANK_ADDR_WIDTH +: `GLB_BANK_SEL_WIDTH];
    endfunction

    function automatic glb_bank_addr_t word_field(glb_addr_t a);
        return a[`GLB_BANK_ADDR_WIDTH-1:0];
    endfunction

    task automatic check_data(string name, glb_data_t expected, glb_data_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_valid(string name, logic expected, logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_addr(string name, glb_addr_t expected, glb_addr_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic store_if_local(glb_addr_t addr, glb_data_t data);
        if (tile_field(addr) == glb_tile_id) begin
            ref_mem[bank_field(addr)][word_field(addr)] = data;
            written[bank_field(addr)][word_field(addr)] = 1'b1;
        end
    endtask

    // requests as the DUT samples them on an active edge
    task automatic sample_requests();
        rsp_t r;
        logic st_on;
        logic ld_on;
        st_on = (cfg_st_dma_mode != 2'b00);
        ld_on = (cfg_ld_dma_mode != 2'b00);
        r.due = act_cycles + LATENCY;
        // a read on the same edge as a write still sees the old word
        if (proc_rd_en && tile_field(proc_rd_addr) == glb_tile_id) begin
            r.data = ref_mem[bank_field(proc_rd_addr)][word_field(proc_rd_addr)];
            proc_q.push_back(r);
        end else if (ld_on && strm_dma_rd_en && tile_field(strm_dma_rd_addr) == glb_tile_id) begin
            r.data = ref_mem[bank_field(strm_dma_rd_addr)][word_field(strm_dma_rd_addr)];
            strm_q.push_back(r);
        end else if (!ld_on && strm_rtr_rd_en && tile_field(strm_rtr_rd_addr) == glb_tile_id) begin
            r.data = ref_mem[bank_field(strm_rtr_rd_addr)][word_field(strm_rtr_rd_addr)];
            strm_q.push_back(r);
        end
        if (proc_wr_en) begin
            store_if_local(proc_wr_addr, proc_wr_data);
        end else if (st_on) begin
            if (strm_dma_wr_en) begin
                store_if_local(strm_dma_wr_addr, strm_dma_wr_data);
            end
        end else if (strm_rtr_wr_en) begin
            store_if_local(strm_rtr_wr_addr, strm_rtr_wr_data);
        end
    endtask

    // a response due at edge n is on the port between edges n-1 and n
    task automatic check_responses();
        if (proc_q.size() > 0 && proc_q[0].due == act_cycles + 1) begin
            check_valid("proc_rsp_valid", 1'b1, proc_rsp_valid);
            check_data("proc_rsp_data", proc_q[0].data, proc_rsp_data);
        end else begin
            check_valid("proc_rsp_valid", 1'b0, proc_rsp_valid);
        end
        if (strm_q.size() > 0 && strm_q[0].due == act_cycles + 1) begin
            check_valid("strm_rtr_rsp_valid", 1'b1, strm_rtr_rsp_valid);
            check_data("strm_rtr_rsp_data", strm_q[0].data, strm_rtr_rsp_data);
        end else begin
            check_valid("strm_rtr_rsp_valid", chain_rsp_valid, strm_rtr_rsp_valid);
            check_data("strm_rtr_rsp_data", chain_rsp_data, strm_rtr_rsp_data);
        end
        if (cfg_ld_dma_mode != 2'b00) begin
            check_valid("strm_dma_rsp_valid", chain_rsp_valid, strm_dma_rsp_valid);
            check_data("strm_dma_rsp_data", chain_rsp_data, strm_dma_rsp_data);
        end else begin
            check_valid("strm_dma_rsp_valid", 1'b0, strm_dma_rsp_valid);
            check_data("strm_dma_rsp_data", '0, strm_dma_rsp_data);
        end
    endtask

    // stream packets go down the chain whatever their tile field
    task automatic check_chain();
        if (cfg_st_dma_mode != 2'b00) begin
            check_valid("chain_wr_en", strm_dma_wr_en, chain_wr_en);
            check_addr("chain_wr_addr", strm_dma_wr_addr, chain_wr_addr);
            check_data("chain_wr_data", strm_dma_wr_data, chain_wr_data);
        end else begin
            check_valid("chain_wr_en", strm_rtr_wr_en, chain_wr_en);
            check_addr("chain_wr_addr", strm_rtr_wr_addr, chain_wr_addr);
            check_data("chain_wr_data", strm_rtr_wr_data, chain_wr_data);
        end
        if (cfg_ld_dma_mode != 2'b00) begin
            check_valid("chain_rd_en", strm_dma_rd_en, chain_rd_en);
            check_addr("chain_rd_addr", strm_dma_rd_addr, chain_rd_addr);
        end else begin
            check_valid("chain_rd_en", strm_rtr_rd_en, chain_rd_en);
            check_addr("chain_rd_addr", strm_rtr_rd_addr, chain_rd_addr);
        end
    endtask

    // one clock; returns 1 ns after the edge, where new stimulus goes
    task automatic cycle();
        @(posedge clk);
        if (clk_en && !reset) begin
            act_cycles++;
            while (proc_q.size() > 0 && proc_q[0].due <= act_cycles) begin
                void'(proc_q.pop_front());
            end
            while (strm_q.size() > 0 && strm_q[0].due <= act_cycles) begin
                void'(strm_q.pop_front());
            end
            sample_requests();
        end
        #1;
        check_responses();
        check_chain();
    endtask

    task automatic idle(int n);
        repeat (n) cycle();
    endtask

    task automatic drain();
        while (proc_q.size() > 0 || strm_q.size() > 0) begin
            cycle();
        end
    endtask

    task automatic proc_write(glb_addr_t addr, glb_data_t data);
        proc_wr_en   = 1'b1;
        proc_wr_addr = addr;
        proc_wr_data = data;
        cycle();
        proc_wr_en = 1'b0;
    endtask

    task automatic proc_read(glb_addr_t addr);
        proc_rd_en   = 1'b1;
        proc_rd_addr = addr;
        cycle();
        proc_rd_en = 1'b0;
    endtask

    task automatic proc_rw_each_bank();
        glb_addr_t a;
        for (int b = 0; b < `GLB_BANKS_PER_TILE; b++) begin
            a = make_addr(TILE_ID, glb_bank_sel_t'(b), glb_bank_addr_t'(b * 17 + 3));
            proc_write(a, next_random());
            proc_read(a);
            drain();
        end
    endtask

    task automatic tile_filtering();
        glb_addr_t local_a;
        glb_addr_t remote_a;
        local_a  = make_addr(TILE_ID, 2'd3, 8'h10);
        remote_a = make_addr(TILE_ID ^ 3'd1, 2'd3, 8'h10);
        proc_write(local_a, next_random());
        proc_write(remote_a, next_random());
        proc_read(remote_a);
        strm_rtr_wr_en   = 1'b1;
        strm_rtr_wr_addr = remote_a;
        strm_rtr_wr_data = next_random();
        strm_dma_wr_en   = 1'b1;
        strm_dma_wr_addr = make_addr(TILE_ID ^ 3'd2, 2'd3, 8'h10);
        strm_dma_wr_data = next_random();
        cycle();
        cfg_st_dma_mode = 2'd1;
        cycle();
        strm_rtr_wr_en   = 1'b0;
        strm_dma_wr_en   = 1'b0;
        cfg_ld_dma_mode  = 2'd1;
        strm_dma_rd_en   = 1'b1;
        strm_dma_rd_addr = remote_a;
        cycle();
        cfg_ld_dma_mode  = 2'd0;
        strm_rtr_rd_en   = 1'b1;
        strm_rtr_rd_addr = remote_a;
        cycle();
        strm_rtr_rd_en  = 1'b0;
        strm_dma_rd_en  = 1'b0;
        cfg_st_dma_mode = 2'd0;
        proc_read(local_a);
        drain();
    endtask

    task automatic write_priority();
        glb_addr_t a;
        a = make_addr(TILE_ID, 2'd0, 8'h22);
        proc_wr_en       = 1'b1;
        proc_wr_addr     = a;
        proc_wr_data     = next_random();
        strm_rtr_wr_en   = 1'b1;
        strm_rtr_wr_addr = a;
        strm_rtr_wr_data = next_random();
        cycle();
        proc_wr_en     = 1'b0;
        strm_rtr_wr_en = 1'b0;
        proc_read(a);
        // router alone lands, dma ignored while st dma is off
        strm_rtr_wr_en   = 1'b1;
        strm_rtr_wr_data = next_random();
        strm_dma_wr_en   = 1'b1;
        strm_dma_wr_addr = a;
        strm_dma_wr_data = next_random();
        cycle();
        strm_rtr_wr_en = 1'b0;
        strm_dma_wr_en = 1'b0;
        proc_read(a);
        cfg_st_dma_mode  = 2'd2;
        strm_dma_wr_en   = 1'b1;
        strm_dma_wr_data = next_random();
        strm_rtr_wr_en   = 1'b1;
        strm_rtr_wr_data = next_random();
        cycle();
        strm_rtr_wr_en = 1'b0;
        strm_dma_wr_en = 1'b0;
        proc_read(a);
        proc_wr_en       = 1'b1;
        proc_wr_data     = next_random();
        strm_dma_wr_en   = 1'b1;
        strm_dma_wr_data = next_random();
        cycle();
        proc_wr_en     = 1'b0;
        strm_dma_wr_en = 1'b0;
        proc_read(a);
        drain();
        cfg_st_dma_mode = 2'd0;
    endtask

    task automatic read_routing();
        glb_addr_t a;
        glb_addr_t b;
        a = make_addr(TILE_ID, 2'd1, 8'h40);
        b = make_addr(TILE_ID, 2'd2, 8'h41);
        proc_write(a, next_random());
        proc_write(b, next_random());
        for (int mode = 0; mode < 2; mode++) begin
            cfg_ld_dma_mode  = (mode == 0) ? 2'd0 : 2'd3;
            strm_rtr_rd_en   = 1'b1;
            strm_rtr_rd_addr = a;
            strm_dma_rd_en   = 1'b1;
            strm_dma_rd_addr = b;
            cycle();
            strm_rtr_rd_en = 1'b0;
            strm_dma_rd_en = 1'b0;
            // chain traffic overlaps the local response, then runs alone
            chain_rsp_valid = 1'b1;
            chain_rsp_data  = next_random();
            idle(2);
            chain_rsp_data = next_random();
            idle(2);
            chain_rsp_valid = 1'b0;
            drain();
        end
        cfg_ld_dma_mode = 2'd0;
    endtask

    task automatic clock_enable_stall();
        glb_addr_t a;
        a = make_addr(TILE_ID, 2'd2, 8'h7f);
        proc_write(a, next_random());
        proc_read(a);
        cycle();
        clk_en = 1'b0;
        idle(4);
        clk_en = 1'b1;
        drain();
        // stall while the response sits on the port
        proc_read(a);
        idle(2);
        clk_en = 1'b0;
        idle(3);
        clk_en = 1'b1;
        drain();
        clk_en = 1'b0;
        proc_write(a, next_random());
        clk_en = 1'b1;
        proc_read(a);
        drain();
    endtask

    task automatic random_sweep();
        logic [31:0]    r;
        glb_bank_addr_t rw;
        for (int i = 0; i < 200; i++) begin
            r  = next_random();
            rw = {3'b000, r[6:2]};
            proc_rd_addr = make_addr(TILE_ID, r[1:0], rw);
            proc_wr_addr = make_addr(TILE_ID, r[8:7], {3'b000, r[13:9]});
            proc_wr_data = next_random();
            // reads only go to words with a known value
            proc_rd_en = (r[14] || r[16]) && written[r[1:0]][rw];
            proc_wr_en = !proc_rd_en || r[15];
            cycle();
        end
        proc_wr_en = 1'b0;
        proc_rd_en = 1'b0;
        drain();
    endtask

    initial begin
        clk_en           = 1'b1;
        glb_tile_id      = TILE_ID;
        cfg_st_dma_mode  = 2'd0;
        cfg_ld_dma_mode  = 2'd0;
        proc_wr_en       = 1'b0;
        proc_wr_addr     = '0;
        proc_wr_data     = '0;
        proc_rd_en       = 1'b0;
        proc_rd_addr     = '0;
        strm_dma_wr_en   = 1'b0;
        strm_dma_wr_addr = '0;
        strm_dma_wr_data = '0;
        strm_dma_rd_en   = 1'b0;
        strm_dma_rd_addr = '0;
        strm_rtr_wr_en   = 1'b0;
        strm_rtr_wr_addr = '0;
        strm_rtr_wr_data = '0;
        strm_rtr_rd_en   = 1'b0;
        strm_rtr_rd_addr = '0;
        chain_rsp_valid  = 1'b0;
        chain_rsp_data   = '0;
        for (int b = 0; b < `GLB_BANKS_PER_TILE; b++) begin
            for (int w = 0; w < WORDS; w++) begin
                written[b][w] = 1'b0;
                ref_mem[b][w] = '0;
            end
        end
        @(negedge reset);
        idle(2);
        proc_rw_each_bank();
        tile_filtering();
        write_priority();
        read_routing();
        clock_enable_stall();
        random_sweep();
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns, the tests did not reach their end", TIMEOUT_NS);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
source/glb_pkg.sv
source/glb_bank.sv
source/glb_core_switch.sv
source/glb_tile.sv
sim/glb_tb_clock.sv
sim/glb_tile_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the tile testbench with Verilator and run it.
set -euo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f vlog.f --top-module glb_tile_tb -o glb_tile_sim

./obj_dir/glb_tile_sim 2>&1 | tee sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi

if ! grep -q "Testbench passed" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
